/* bootrom.hex */
// Boot ROM contents, one 32-bit hex word per line for word indices 0 to 15
f1402573
00000597
02058593
30559073
10500073
0000006f
00000013
00100293
80000337
00532023
00032383
fe039ce3
12345678
9abcdef0
0f1e2d3c
a5a55a5a

/* common/mempool_config.svh */
// Address map and sizes of the memory subsystem
// The L2 window is derived from the bank count and depth, so keep both powers of two

`ifndef MEMPOOL_CONFIG_SVH
`define MEMPOOL_CONFIG_SVH

// L2 memory, word interleaved over the banks
`define MEMPOOL_L2_BASE        32'h8000_0000
`define MEMPOOL_NUM_L2_BANKS   4
`define MEMPOOL_L2_BANK_WORDS  256

// Boot ROM window, end address is inclusive
`define MEMPOOL_BOOTROM_BASE   32'hA000_0000
`define MEMPOOL_BOOTROM_END    32'hA000_FFFF
`define MEMPOOL_BOOTROM_WORDS  16

// Control registers, end address is exclusive
`define MEMPOOL_CTRL_BASE      32'h4000_0000
`define MEMPOOL_CTRL_END       32'h4001_0000

`define MEMPOOL_NUM_CORES      8

`endif

/* common/mempool_pkg.sv */
// Shared types of the memory subsystem
// Widths of the L2 index and the core mask follow the config header

`include "mempool_config.svh"

package mempool_pkg;

  typedef logic [31:0] addr_t; // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t; // One enable per data byte

  // Word index over all L2 banks
  typedef logic [$clog2(`MEMPOOL_NUM_L2_BANKS * `MEMPOOL_L2_BANK_WORDS)-1:0] l2_addr_t;

  typedef logic [`MEMPOOL_NUM_CORES-1:0] core_mask_t;

  // Target of a request, RegionNone answers with an error
  typedef enum logic [1:0] {
    RegionL2,
    RegionBootrom,
    RegionCtrl,
    RegionNone
  } region_e;

endpackage : mempool_pkg

/* design/bootrom.sv */
// Boot ROM with synchronous read, contents from bootrom.hex
// The hex file must sit in the simulation working directory

`timescale 1ns/1ns
`include "mempool_config.svh"

module bootrom
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       req_i,
  input  logic [3:0] idx_i,
  output data_t      rdata_o
);

  data_t rom [`MEMPOOL_BOOTROM_WORDS];

  initial begin
    $readmemh("bootrom.hex", rom);
  end

  // Output holds the last word read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom[idx_i];
    end
  end

endmodule : bootrom

/* design/ctrl_registers.sv */
// Control registers: eoc at 0x0, wake-up at 0x4, core count at 0x8
// Unknown offsets read zero and drop writes

`timescale 1ns/1ns
`include "mempool_config.svh"

module ctrl_registers
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      off_i,
  input  data_t      wdata_i,
  output data_t      rdata_o,
  output logic       eoc_valid_o,
  output core_mask_t wake_up_o
);

  localparam addr_t eoc_off       = 32'h0;
  localparam addr_t wake_up_off   = 32'h4;
  localparam addr_t num_cores_off = 32'h8;

  data_t      eoc_q;
  core_mask_t wake_up_q;
  logic       wr;
  logic       rd;

  assign wr = req_i && we_i;
  assign rd = req_i && !we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      wake_up_q <= '0; // Wake-up is a one-cycle pulse
      if (wr && (off_i == eoc_off)) begin
        eoc_q <= wdata_i;
      end
      if (wr && (off_i == wake_up_off)) begin
        wake_up_q <= wdata_i[$bits(core_mask_t)-1:0];
      end
    end
  end

  // Read port, wake-up reads back as zero
  always_ff @(posedge clk_i) begin
    if (rd) begin
      case (off_i)
        eoc_off:       rdata_o <= eoc_q;
        num_cores_off: rdata_o <= data_t'(`MEMPOOL_NUM_CORES);
        default:       rdata_o <= '0;
      endcase
    end
  end

  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

/* design/mempool_addr_decode.sv */
// Combinational address decode, at most one target strobe per request
// Boot ROM writes decode as unmapped and get an error

`timescale 1ns/1ns
`include "mempool_config.svh"

module mempool_addr_decode
  import mempool_pkg::*;
(
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  output region_e  region_o,
  output logic     l2_req_o,
  output logic     rom_req_o,
  output logic     ctrl_req_o,
  output l2_addr_t l2_addr_o,
  output logic [3:0] rom_idx_o,
  output addr_t    ctrl_off_o
);

  localparam int    l2_idx_w = $bits(l2_addr_t);
  localparam addr_t l2_end   = `MEMPOOL_L2_BASE
                               + `MEMPOOL_NUM_L2_BANKS * `MEMPOOL_L2_BANK_WORDS * 4;

  logic in_l2;
  logic in_rom;
  logic in_ctrl;

  assign in_l2   = (addr_i >= `MEMPOOL_L2_BASE) && (addr_i < l2_end);
  assign in_rom  = (addr_i >= `MEMPOOL_BOOTROM_BASE) && (addr_i <= `MEMPOOL_BOOTROM_END);
  assign in_ctrl = (addr_i >= `MEMPOOL_CTRL_BASE) && (addr_i < `MEMPOOL_CTRL_END);

  always_comb begin
    region_o = RegionNone;
    if (in_l2) begin
      region_o = RegionL2;
    end else if (in_rom && !we_i) begin // ROM is read-only
      region_o = RegionBootrom;
    end else if (in_ctrl) begin
      region_o = RegionCtrl;
    end
  end

  assign l2_req_o   = req_i && (region_o == RegionL2);
  assign rom_req_o  = req_i && (region_o == RegionBootrom);
  assign ctrl_req_o = req_i && (region_o == RegionCtrl);

  // Word offsets inside each window
  assign l2_addr_o  = addr_i[l2_idx_w+1:2];
  assign rom_idx_o  = addr_i[5:2]; // Aliases over the whole ROM window
  assign ctrl_off_o = addr_i - `MEMPOOL_CTRL_BASE;

endmodule : mempool_addr_decode

/* design/mempool_resp_mux.sv */
// Response stage, one cycle after each request
// Writes return zero data, unmapped requests raise err_o

`timescale 1ns/1ns

module mempool_resp_mux
  import mempool_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_i,
  input  region_e region_i,
  input  data_t   l2_rdata_i,
  input  data_t   rom_rdata_i,
  input  data_t   ctrl_rdata_i,
  input  logic    we_i,
  output logic    rvalid_o,
  output data_t   rdata_o,
  output logic    err_o
);

  logic    valid_q;
  logic    we_q;
  region_e region_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= RegionNone;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        we_q     <= we_i;
        region_q <= region_i;
      end
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (region_q == RegionNone);

  always_comb begin
    rdata_o = '0;
    if (valid_q && !we_q) begin
      case (region_q)
        RegionL2:      rdata_o = l2_rdata_i;
        RegionBootrom: rdata_o = rom_rdata_i;
        RegionCtrl:    rdata_o = ctrl_rdata_i;
        default:       rdata_o = '0; // Unmapped
      endcase
    end
  end

endmodule : mempool_resp_mux

/* design/mempool_system.sv */
// Memory subsystem behind one host port, every request accepted at once
// Responses come exactly one cycle later, there is no back-pressure

`timescale 1ns/1ns

module mempool_system
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  input  strb_t      strb_i,
  output logic       rvalid_o,
  output data_t      rdata_o,
  output logic       err_o,
  output logic       eoc_valid_o,
  output core_mask_t wake_up_o
);

  region_e    region;
  logic       l2_req;
  logic       rom_req;
  logic       ctrl_req;
  l2_addr_t   l2_addr;
  logic [3:0] rom_idx;
  addr_t      ctrl_off;
  data_t      l2_rdata;
  data_t      rom_rdata;
  data_t      ctrl_rdata;

  mempool_addr_decode i_addr_decode (
    .req_i     (req_i   ),
    .we_i      (we_i    ),
    .addr_i    (addr_i  ),
    .region_o  (region  ),
    .l2_req_o  (l2_req  ),
    .rom_req_o (rom_req ),
    .ctrl_req_o(ctrl_req),
    .l2_addr_o (l2_addr ),
    .rom_idx_o (rom_idx ),
    .ctrl_off_o(ctrl_off)
  );

  l2_mem_banks i_l2_mem (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .req_i  (l2_req  ),
    .we_i   (we_i    ),
    .addr_i (l2_addr ),
    .wdata_i(wdata_i ),
    .strb_i (strb_i  ),
    .rdata_o(l2_rdata)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .idx_i  (rom_idx  ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (we_i       ),
    .off_i      (ctrl_off   ),
    .wdata_i    (wdata_i    ),
    .rdata_o    (ctrl_rdata ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

  mempool_resp_mux i_resp_mux (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .req_i       (req_i     ),
    .region_i    (region    ),
    .l2_rdata_i  (l2_rdata  ),
    .rom_rdata_i (rom_rdata ),
    .ctrl_rdata_i(ctrl_rdata),
    .we_i        (we_i      ),
    .rvalid_o    (rvalid_o  ),
    .rdata_o     (rdata_o   ),
    .err_o       (err_o     )
  );

endmodule : mempool_system

/* files.f */
+incdir+common
common/mempool_pkg.sv
design/mempool_addr_decode.sv
l2/l2_mem_banks.sv
design/bootrom.sv
design/ctrl_registers.sv
design/mempool_resp_mux.sv
design/mempool_system.sv
tb/tb_mempool_system.sv

/* l2/l2_mem_banks.sv */
// Word-interleaved L2 banks, single port each, no reset on contents
// Read data is held until the next read

`timescale 1ns/1ns
`include "mempool_config.svh"

module l2_mem_banks
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  logic     we_i,
  input  l2_addr_t addr_i,
  input  data_t    wdata_i,
  input  strb_t    strb_i,
  output data_t    rdata_o
);

  localparam int num_banks  = `MEMPOOL_NUM_L2_BANKS;
  localparam int bank_sel_w = $clog2(num_banks);
  localparam int row_w      = $bits(l2_addr_t) - bank_sel_w;

  logic [bank_sel_w-1:0]   bank_sel;
  logic [bank_sel_w-1:0]   bank_sel_q; // Bank of the last read
  logic [row_w-1:0]        row;
  data_t [num_banks-1:0]   bank_rdata;

  // Low index bits pick the bank, the rest the row
  assign bank_sel = addr_i[bank_sel_w-1:0];
  assign row      = addr_i[$bits(l2_addr_t)-1:bank_sel_w];

  for (genvar b = 0; b < num_banks; b++) begin : gen_banks
    data_t mem [`MEMPOOL_L2_BANK_WORDS];
    data_t rdata_q;
    logic  bank_en;

    assign bank_en = req_i && (bank_sel == bank_sel_w'(b));

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (we_i) begin
          for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb_i[i]) begin
              mem[row][8*i +: 8] <= wdata_i[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank_sel_q <= '0;
    end else if (req_i && !we_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule : l2_mem_banks

/* run.sh */
#!/bin/sh
# Build with Verilator and run from the project root, where bootrom.hex lives
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mempool_system -f files.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tb/tb_mempool_system.sv */
// Must run from the project root, where bootrom.hex is read for the boot ROM model
// L2 is filled before any read since its contents are undefined after reset

`timescale 1ns/1ns
`include "mempool_config.svh"

module tb_mempool_system;
  import mempool_pkg::*;

  localparam addr_t l2_base    = `MEMPOOL_L2_BASE;
  localparam int    l2_words   = `MEMPOOL_NUM_L2_BANKS * `MEMPOOL_L2_BANK_WORDS;
  localparam addr_t l2_end     = l2_base + l2_words * 4;
  localparam addr_t rom_base   = `MEMPOOL_BOOTROM_BASE;
  localparam addr_t rom_end    = `MEMPOOL_BOOTROM_END;
  localparam addr_t ctrl_base  = `MEMPOOL_CTRL_BASE;
  localparam addr_t ctrl_end   = `MEMPOOL_CTRL_END;
  localparam logic [31:0] lfsr_poly = 32'h8020_0003;
  localparam int    num_random = 400;
  localparam int    num_mixed  = 300;
  localparam int    num_total  = l2_words + num_random + num_mixed + 200; // Directed ones too
  localparam int    timeout_ns = (16 + 2 * num_total) * 10 + 1000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req;
  logic       we;
  addr_t      addr;
  data_t      wdata;
  strb_t      strb;
  logic       rvalid;
  data_t      rdata;
  logic       err;
  logic       eoc_valid;
  core_mask_t wake_up;

  // Reference model state
  data_t       l2_model [int];
  data_t       rom_model [`MEMPOOL_BOOTROM_WORDS];
  data_t       eoc_model;
  core_mask_t  wake_exp;
  data_t       exp_data_q [$]; // Holds at most one response
  logic        exp_err_q [$];
  string       exp_name_q [$];
  logic [31:0] lfsr_q;
  int          num_checks;
  int          data_errs;
  int          flag_errs;
  int          mask_errs;

  always #5 clk = ~clk;

  mempool_system dut0 (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_i      (req      ),
    .we_i       (we       ),
    .addr_i     (addr     ),
    .wdata_i    (wdata    ),
    .strb_i     (strb     ),
    .rvalid_o   (rvalid   ),
    .rdata_o    (rdata    ),
    .err_o      (err      ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_poly) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic data_t fill_word(input int i);
    return {6'h2a, i[9:0], ~i[9:0], 6'h15}; // Unique per word index
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    num_checks++;
    if (act !== exp) begin
      data_errs++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      flag_errs++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t exp, input core_mask_t act);
    num_checks++;
    if (act !== exp) begin
      mask_errs++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Checks the response to the request of the previous cycle
  task automatic check_response();
    string name;
    if (exp_data_q.size() > 0) begin
      name = exp_name_q.pop_front();
      check_flag({name, " rvalid"}, 1'b1, rvalid);
      check_data({name, " rdata"}, exp_data_q.pop_front(), rdata);
      check_flag({name, " err"}, exp_err_q.pop_front(), err);
    end else begin
      check_flag("idle rvalid", 1'b0, rvalid);
      check_flag("idle err", 1'b0, err);
    end
    check_flag("eoc_valid", eoc_model[0], eoc_valid);
    check_mask("wake_up", wake_exp, wake_up); // Pulse lasts one cycle only
    wake_exp = '0;
  endtask

  task automatic idle();
    @(negedge clk);
    check_response();
    req = 1'b0;
    we  = 1'b0;
  endtask

  // Drives one request and predicts its response from the memory map
  task automatic send(input logic w, input addr_t a, input data_t d, input strb_t s,
                      input string name);
    data_t exp_rdata;
    logic  exp_err;
    data_t word;
    int    idx;
    addr_t off;
    @(negedge clk);
    check_response();
    req       = 1'b1;
    we        = w;
    addr      = a;
    wdata     = d;
    strb      = s;
    exp_rdata = '0;
    exp_err   = 1'b0;
    if (a >= l2_base && a < l2_end) begin
      idx = int'((a - l2_base) >> 2);
      if (w) begin
        word = l2_model[idx];
        for (int b = 0; b < 4; b++) begin
          if (s[b]) begin
            word[8*b +: 8] = d[8*b +: 8];
          end
        end
        l2_model[idx] = word;
      end else begin
        exp_rdata = l2_model[idx];
      end
    end else if (a >= rom_base && a <= rom_end) begin
      if (w) begin
        exp_err = 1'b1;
      end else begin
        exp_rdata = rom_model[a[5:2]]; // Window aliases the 16 words
      end
    end else if (a >= ctrl_base && a < ctrl_end) begin
      off = a - ctrl_base;
      if (w && off == 32'h0) begin
        eoc_model = d;
      end
      if (w && off == 32'h4) begin
        wake_exp = core_mask_t'(d);
      end
      if (!w && off == 32'h0) begin
        exp_rdata = eoc_model;
      end
      if (!w && off == 32'h8) begin
        exp_rdata = `MEMPOOL_NUM_CORES;
      end
    end else begin
      exp_err = 1'b1; // Unmapped
    end
    exp_data_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    exp_name_q.push_back(name);
  endtask

  initial begin
    #(timeout_ns);
    $display("Error: the run timed out after %0d ns without reaching its end", timeout_ns);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic  w;
    addr_t a;
    lfsr_q     = 32'hd264_eb79;
    eoc_model  = '0;
    wake_exp   = '0;
    num_checks = 0;
    data_errs  = 0;
    flag_errs  = 0;
    mask_errs  = 0;
    rst_n      = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    strb       = '0;
    $readmemh("bootrom.hex", rom_model);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // No rising edge has passed since release, so the reset values are still visible
    check_flag("reset rvalid", 1'b0, rvalid);
    check_flag("reset err", 1'b0, err);
    check_flag("reset eoc_valid", 1'b0, eoc_valid);
    check_mask("reset wake_up", '0, wake_up);

    for (int i = 0; i < l2_words; i++) begin
      send(1'b1, l2_base + addr_t'(i * 4), fill_word(i), 4'hf, "l2 fill");
    end
    for (int i = 0; i < num_random; i++) begin
      w = (rand_bits(1) != 0);
      a = l2_base + (rand_bits(10) << 2);
      send(w, a, rand_bits(32), strb_t'(rand_bits(4)), "l2 random");
      if (rand_bits(2) == 0) begin
        idle(); // Occasional gap between requests
      end
    end

    // Back to back over all regions
    for (int i = 0; i < num_mixed; i++) begin
      case (rand_bits(2))
        0:       a = l2_base + (rand_bits(10) << 2);
        1:       a = rom_base + (rand_bits(14) << 2);
        2:       a = ctrl_base + (rand_bits(4) << 2);
        default: a = rand_bits(32);
      endcase
      w = (rand_bits(1) != 0);
      send(w, a, rand_bits(32), strb_t'(rand_bits(4)), "mixed");
    end

    for (int i = 0; i < 32; i++) begin
      send(1'b0, rom_base + (rand_bits(14) << 2), '0, '0, "bootrom read");
    end
    send(1'b1, rom_base + 32'h8, 32'h1234_5678, 4'hf, "bootrom write");

    send(1'b1, ctrl_base, 32'h0000_0001, 4'hf, "eoc set");
    idle();
    send(1'b0, ctrl_base, '0, '0, "eoc read");
    send(1'b1, ctrl_base, 32'h0000_0002, 4'hf, "eoc clear");
    idle();
    send(1'b1, ctrl_base + 32'h4, 32'h0000_00a5, 4'hf, "wake_up write");
    idle();
    idle();
    send(1'b0, ctrl_base + 32'h4, '0, '0, "wake_up read");
    send(1'b0, ctrl_base + 32'h8, '0, '0, "num_cores read");

    send(1'b1, l2_end, 32'hdead_beef, 4'hf, "unmapped l2 end");
    send(1'b1, l2_base - 32'h4, 32'hdead_beef, 4'hf, "unmapped below l2");
    send(1'b0, ctrl_end, '0, '0, "unmapped ctrl end");
    send(1'b0, rom_end + 32'h1, '0, '0, "unmapped rom end");
    for (int i = 0; i < 64; i++) begin
      w = (rand_bits(1) != 0);
      a = 32'hc000_0000 | rand_bits(28);
      send(w, a, rand_bits(32), 4'hf, "unmapped random");
    end
    send(1'b0, l2_base, '0, '0, "l2 word 0 after unmapped");
    for (int i = 0; i < 64; i++) begin
      send(1'b0, l2_base + (rand_bits(10) << 2), '0, '0, "l2 after unmapped");
    end
    idle();
    idle();

    $display("Checks: %0d, data errors: %0d, flag errors: %0d, mask errors: %0d",
             num_checks, data_errs, flag_errs, mask_errs);
    if (data_errs + flag_errs + mask_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_system
